/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert --timescale 1ns/100ps -j 0
TOP ?= rv_core_tb
FILELIST ?= rv_core.f
LOG ?= sim.log
PASS_MSG ?= TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove the build folder and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* alu.sv */
module alu
    (
        input rv_pkg::word_t a,
        input rv_pkg::word_t b,
        input rv_pkg::alu_func_e func,
        output rv_pkg::word_t result,
        output logic zero
    );

    import rv_pkg::*;

    always_comb
    begin
        case (func)
            alu_add:
                result = a + b;
            alu_xor:
                result = a ^ b;
            default:
                result = '0;
        endcase
    end

    // beq compares by xor, so equal operands give an all-zero result
    assign zero = (result == '0);

endmodule

/* exu.sv */
module exu
    (
        input rv_pkg::dec_t dec,
        input rv_pkg::word_t pc,
        input rv_pkg::word_t src1,
        input rv_pkg::word_t src2,
        input rv_pkg::word_t alu_result,
        input logic alu_zero,
        output rv_pkg::word_t alu_a,
        output rv_pkg::word_t alu_b,
        output rv_pkg::alu_func_e alu_func,
        output rv_pkg::word_t pc_step,
        output logic pc_w_en,
        output rv_pkg::word_t rd_data,
        output logic gpr_w_en,
        output rv_pkg::store_t store,
        output logic mem_w_en,
        output logic halt_req
    );

    import rv_pkg::*;

    // Entry order follows inst_keys or type_keys
    word_t alu_a_vals [nr_inst_keys];
    word_t alu_b_vals [nr_inst_keys];
    alu_func_e alu_func_vals [nr_inst_keys];
    word_t pc_step_vals [nr_inst_keys];
    word_t rd_data_vals [nr_inst_keys];
    logic halt_vals [nr_inst_keys];
    logic pc_w_en_vals [nr_type_keys];
    logic gpr_w_en_vals [nr_type_keys];
    logic mem_w_en_vals [nr_type_keys];

    // ========================================
    // Keyed by instruction
    // ========================================
    assign alu_a_vals = '{pc, pc, src1, src1, src1, src1, '0};
    assign alu_b_vals = '{dec.imm, inst_bytes, src2, dec.imm, dec.imm, src2, '0};
    assign alu_func_vals = '{alu_add, alu_add, alu_xor, alu_add, alu_add, alu_add, alu_none};
    assign pc_step_vals = '{inst_bytes, dec.imm, alu_zero ? dec.imm : inst_bytes,
                            inst_bytes, inst_bytes, inst_bytes, inst_bytes};
    assign rd_data_vals = '{alu_result, alu_result, '0, '0, alu_result, alu_result, '0};
    assign halt_vals = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};

    key_mux #(.key_t(inst_num_e), .data_t(word_t), .nr_key(nr_inst_keys),
              .keys(inst_keys), .default_out('0))
        alu_a_mux (.key(dec.inst_num), .values(alu_a_vals), .out(alu_a));

    key_mux #(.key_t(inst_num_e), .data_t(word_t), .nr_key(nr_inst_keys),
              .keys(inst_keys), .default_out('0))
        alu_b_mux (.key(dec.inst_num), .values(alu_b_vals), .out(alu_b));

    key_mux #(.key_t(inst_num_e), .data_t(alu_func_e), .nr_key(nr_inst_keys),
              .keys(inst_keys), .default_out(alu_none))
        alu_func_mux (.key(dec.inst_num), .values(alu_func_vals), .out(alu_func));

    key_mux #(.key_t(inst_num_e), .data_t(word_t), .nr_key(nr_inst_keys),
              .keys(inst_keys), .default_out(inst_bytes))
        pc_step_mux (.key(dec.inst_num), .values(pc_step_vals), .out(pc_step));

    key_mux #(.key_t(inst_num_e), .data_t(word_t), .nr_key(nr_inst_keys),
              .keys(inst_keys), .default_out('0))
        rd_data_mux (.key(dec.inst_num), .values(rd_data_vals), .out(rd_data));

    // Unknown words fall to the default and stop the core
    key_mux #(.key_t(inst_num_e), .data_t(logic), .nr_key(nr_inst_keys),
              .keys(inst_keys), .default_out(1'b1))
        halt_mux (.key(dec.inst_num), .values(halt_vals), .out(halt_req));

    // ========================================
    // Keyed by format
    // ========================================
    assign pc_w_en_vals = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1};
    assign gpr_w_en_vals = '{1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1};
    assign mem_w_en_vals = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0};

    key_mux #(.key_t(inst_type_e), .data_t(logic), .nr_key(nr_type_keys),
              .keys(type_keys), .default_out(1'b0))
        pc_w_en_mux (.key(dec.inst_type), .values(pc_w_en_vals), .out(pc_w_en));

    key_mux #(.key_t(inst_type_e), .data_t(logic), .nr_key(nr_type_keys),
              .keys(type_keys), .default_out(1'b0))
        gpr_w_en_mux (.key(dec.inst_type), .values(gpr_w_en_vals), .out(gpr_w_en));

    key_mux #(.key_t(inst_type_e), .data_t(logic), .nr_key(nr_type_keys),
              .keys(type_keys), .default_out(1'b0))
        mem_w_en_mux (.key(dec.inst_type), .values(mem_w_en_vals), .out(mem_w_en));

    // For sw the ALU already forms src1 + imm
    assign store.addr = alu_result;
    assign store.data = src2;

endmodule

/* gpr_file.sv */
module gpr_file
    (
        input logic clk,
        input logic reset,
        input rv_pkg::reg_idx_t rs1,
        input rv_pkg::reg_idx_t rs2,
        input rv_pkg::reg_idx_t rd,
        input rv_pkg::word_t rd_data,
        input logic w_en,
        output rv_pkg::word_t src1,
        output rv_pkg::word_t src2
    );

    import rv_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < 32; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (w_en && rd != '0)
        begin
            regs[rd] <= rd_data;                    // x0 never written
        end
    end

    assign src1 = (rs1 == '0) ? '0 : regs[rs1];
    assign src2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* idu.sv */
module idu
    (
        input rv_pkg::word_t inst,
        output rv_pkg::dec_t dec
    );

    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;
    inst_num_e inst_num;
    inst_type_e inst_type;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // ========================================
    // Immediates
    // ========================================
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // ========================================
    // Classification
    // ========================================
    always_comb
    begin
        inst_num = inst_none;
        inst_type = type_none;
        if (inst == ebreak_word)
        begin
            inst_num = inst_ebreak;
            inst_type = type_i;
        end
        else
        begin
            case (opcode)
                op_auipc:
                begin
                    inst_num = inst_auipc;
                    inst_type = type_u;
                end
                op_jal:
                begin
                    inst_num = inst_jal;
                    inst_type = type_j;
                end
                op_branch:
                    if (funct3 == f3_zero)
                    begin
                        inst_num = inst_beq;
                        inst_type = type_b;
                    end
                op_store:
                    if (funct3 == f3_word)
                    begin
                        inst_num = inst_sw;
                        inst_type = type_s;
                    end
                op_imm:
                    if (funct3 == f3_zero)
                    begin
                        inst_num = inst_addi;
                        inst_type = type_i;
                    end
                op_reg:
                    if (funct3 == f3_zero && funct7 == 7'b0)
                    begin
                        inst_num = inst_add;
                        inst_type = type_r;
                    end
                default:
                    inst_num = inst_none;               // Unknown opcode
            endcase
        end
    end

    always_comb
    begin
        dec.inst_num = inst_num;
        dec.inst_type = inst_type;
        dec.rs1 = inst[19:15];
        dec.rs2 = inst[24:20];
        dec.rd = inst[11:7];
        case (inst_type)
            type_i: dec.imm = imm_i;
            type_s: dec.imm = imm_s;
            type_b: dec.imm = imm_b;
            type_u: dec.imm = imm_u;
            type_j: dec.imm = imm_j;
            default: dec.imm = '0;                  // R format and unknown words
        endcase
    end

endmodule

/* key_mux.sv */
module key_mux
    #(
        parameter type key_t = logic,
        parameter type data_t = logic,
        parameter int nr_key = 1,
        parameter key_t keys [nr_key] = '{default: key_t'(0)},
        parameter data_t default_out = data_t'(0)
    )
    (
        input key_t key,
        input data_t values [nr_key],
        output data_t out
    );

    // Later entries win, but the key tables hold no duplicates
    always_comb
    begin
        out = default_out;
        for (int i = 0; i < nr_key; i++)
        begin
            if (key == keys[i])
            begin
                out = values[i];
            end
        end
    end

endmodule

/* rv_core.f */
rv_pkg.sv
key_mux.sv
idu.sv
gpr_file.sv
alu.sv
exu.sv
rv_core.sv
rv_core_properties.sv
rv_core_tb.sv

/* rv_core.sv */
module rv_core
    (
        input logic clk,
        input logic reset,
        output rv_pkg::word_t inst_addr,
        input rv_pkg::word_t inst,
        output logic mem_w_en,
        output rv_pkg::store_t store,
        output logic halted,
        output logic illegal
    );

    import rv_pkg::*;

    word_t pc;
    word_t pc_next;
    dec_t dec;
    word_t src1;
    word_t src2;
    word_t alu_a;
    word_t alu_b;
    alu_func_e alu_func;
    word_t alu_result;
    logic alu_zero;
    word_t pc_step;
    logic pc_w_en;
    word_t rd_data;
    logic gpr_w_en;
    logic exu_mem_w_en;
    logic halt_req;
    logic run;
    logic commit;

    assign run = !reset && !halted && !illegal;
    assign commit = run && !halt_req;               // Halting instructions write nothing

    assign inst_addr = pc;
    assign pc_next = pc + pc_step;
    assign mem_w_en = exu_mem_w_en && commit;

    // ========================================
    // PC and sticky halt flags
    // ========================================
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc <= base_addr;
            halted <= 1'b0;
            illegal <= 1'b0;
        end
        else if (run)
        begin
            if (halt_req)
            begin
                halted <= 1'b1;
                illegal <= (dec.inst_num == inst_none);
            end
            else if (pc_w_en)
            begin
                pc <= pc_next;
            end
        end
    end

    idu idu0 (.inst(inst), .dec(dec));

    gpr_file gpr0 (.clk(clk), .reset(reset), .rs1(dec.rs1), .rs2(dec.rs2), .rd(dec.rd),
                   .rd_data(rd_data), .w_en(gpr_w_en && commit), .src1(src1), .src2(src2));

    exu exu0 (.dec(dec), .pc(pc), .src1(src1), .src2(src2), .alu_result(alu_result),
              .alu_zero(alu_zero), .alu_a(alu_a), .alu_b(alu_b), .alu_func(alu_func),
              .pc_step(pc_step), .pc_w_en(pc_w_en), .rd_data(rd_data), .gpr_w_en(gpr_w_en),
              .store(store), .mem_w_en(exu_mem_w_en), .halt_req(halt_req));

    alu alu0 (.a(alu_a), .b(alu_b), .func(alu_func), .result(alu_result), .zero(alu_zero));

endmodule

/* rv_core_properties.sv */
module rv_core_properties
    (
        input logic clk,
        input logic reset,
        input rv_pkg::word_t inst_addr,
        input logic mem_w_en,
        input logic halted
    );

    timeunit 1ns;
    timeprecision 100ps;

    // ========================================
    // Halt and fetch rules
    // ========================================
    no_store_in_reset: assert property (@(posedge clk) reset |-> !mem_w_en)
        else $error("Store strobe while reset is high");

    no_store_when_halted: assert property (@(posedge clk) disable iff (reset)
        halted |-> !mem_w_en)
        else $error("Store strobe after halt");

    halted_sticky: assert property (@(posedge clk) disable iff (reset) halted |=> halted)
        else $error("Halted flag dropped without reset");

    pc_frozen: assert property (@(posedge clk) disable iff (reset)
        halted |=> $stable(inst_addr))
        else $error("Fetch address moved after halt");

    pc_aligned: assert property (@(posedge clk) disable iff (reset) inst_addr[1:0] == 2'b00)
        else $error("Fetch address not word aligned");

endmodule

bind rv_core rv_core_properties props0 (.clk(clk), .reset(reset), .inst_addr(inst_addr),
                                        .mem_w_en(mem_w_en), .halted(halted));

/* rv_core_tb.sv */
module rv_core_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import rv_pkg::*;

    localparam int imem_words = 64;
    localparam int halt_timeout = 200;
    localparam word_t imem_bytes = 32'd256;
    localparam word_t probe_store = {7'd0, 5'd2, 5'd1, 3'b010, 5'd4, 7'b0100011};  // sw x2, 4(x1)

    // One instruction as the reference model sees it
    typedef struct packed {
        word_t next_pc;
        logic store_en;
        store_t store;
        logic rd_en;
        reg_idx_t rd;
        word_t rd_val;
        logic halt;
        logic illegal;
    } step_t;

    logic clk;
    logic reset;
    word_t inst_addr;
    word_t inst;
    logic mem_w_en;
    store_t store;
    logic halted;
    logic illegal;

    word_t imem [imem_words];
    word_t imem_off;
    word_t model_pc;
    word_t model_regs [32];
    logic model_run;
    logic model_halted;
    logic model_illegal;
    integer seed;
    string test_name;
    int checks;
    int value_errors;
    int other_errors;

    rv_core dut0 (.clk(clk), .reset(reset), .inst_addr(inst_addr), .inst(inst),
                  .mem_w_en(mem_w_en), .store(store), .halted(halted), .illegal(illegal));

    assign imem_off = inst_addr - base_addr;
    assign inst = (imem_off < imem_bytes && imem_off[1:0] == 2'b00) ? imem[imem_off[7:2]]
                                                                   : fill_word(inst_addr);

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #50 clk = ~clk;
        end
    end

    // ========================================
    // Memory and random helpers
    // ========================================
    function automatic word_t fill_word(input word_t addr);
        return (addr * 32'h9e37_79b9) | 32'h0000_007f;  // Opcode 7f never decodes
    endfunction

    function automatic word_t read_imem(input word_t addr);
        word_t off;
        off = addr - base_addr;
        if (off < imem_bytes && off[1:0] == 2'b00)
            return imem[off[7:2]];
        return fill_word(addr);
    endfunction

    function automatic word_t rand_word();
        return $random(seed);
    endfunction

    function automatic reg_idx_t rand_reg();
        word_t r;
        r = rand_word();
        return {2'b00, r[2:0]};                         // x0 to x7 only
    endfunction

    // ========================================
    // Reference model
    // ========================================
    function automatic step_t iss_step(input word_t pc, input word_t regs [32], input word_t w);
        step_t s;
        word_t a;
        word_t b;
        a = regs[w[19:15]];
        b = regs[w[24:20]];
        s = '0;
        s.next_pc = pc + 32'd4;
        s.rd = w[11:7];
        s.store.addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
        s.store.data = b;
        if (w == 32'h0010_0073)
            s.halt = 1'b1;                              // ebreak
        else if (w[6:0] == 7'b0010111)
        begin
            s.rd_en = 1'b1;
            s.rd_val = pc + {w[31:12], 12'b0};
        end
        else if (w[6:0] == 7'b1101111)
        begin
            s.rd_en = 1'b1;
            s.rd_val = pc + 32'd4;
            s.next_pc = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        end
        else if (w[6:0] == 7'b1100011 && w[14:12] == 3'b000)
        begin
            if (a == b)
                s.next_pc = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        end
        else if (w[6:0] == 7'b0100011 && w[14:12] == 3'b010)
            s.store_en = 1'b1;
        else if (w[6:0] == 7'b0010011 && w[14:12] == 3'b000)
        begin
            s.rd_en = 1'b1;
            s.rd_val = a + {{20{w[31]}}, w[31:20]};
        end
        else if (w[6:0] == 7'b0110011 && w[14:12] == 3'b000 && w[31:25] == 7'b0)
        begin
            s.rd_en = 1'b1;
            s.rd_val = a + b;
        end
        else
        begin
            s.halt = 1'b1;
            s.illegal = 1'b1;
        end
        return s;
    endfunction

    // ========================================
    // Compare tasks
    // ========================================
    task automatic check_word(input string what, input word_t expected, input word_t actual);
        checks++;
        if (actual !== expected)
        begin
            $display("ERROR %s: %s expected %h actual %h", test_name, what, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_store(input string what, input store_t expected, input store_t actual);
        checks++;
        if (actual !== expected)
        begin
            $display("ERROR %s: %s expected addr %h data %h actual addr %h data %h", test_name,
                     what, expected.addr, expected.data, actual.addr, actual.data);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string what, input logic expected, input logic actual);
        checks++;
        if (actual !== expected)
        begin
            $display("ERROR %s: %s expected %b actual %b", test_name, what, expected, actual);
            value_errors++;
        end
    endtask

    // ========================================
    // Program generation
    // ========================================
    task automatic load_program(input logic end_illegal);
        int i;
        int a;
        int end_idx;
        int room;
        int skip;
        word_t r;
        word_t imm;
        logic [12:0] boff;
        logic [20:0] joff;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        for (i = 0; i < imem_words; i++)
            imem[i] = fill_word(base_addr + 32'(i) * 32'd4);
        for (i = 1; i < 8; i++)
        begin
            r = rand_word();
            imem[i - 1] = {r[11:0], 5'd0, 3'b000, 5'(i), 7'b0010011};     // addi xi, x0, imm
        end
        r = rand_word();
        end_idx = 24 + int'(r[2:0]);
        a = 7;
        while (a < end_idx)
        begin
            r = rand_word();
            imm = rand_word();
            rd = rand_reg();
            rs1 = rand_reg();
            rs2 = rand_reg();
            room = end_idx - a;
            case (r[2:0])
                3'd0: imem[a] = {7'd0, rs2, rs1, 3'b000, rd, 7'b0110011};
                3'd1, 3'd7: imem[a] = {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
                3'd2: imem[a] = {imm[31:12], rd, 7'b0010111};
                3'd3, 3'd4: imem[a] = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
                3'd5:
                begin
                    if (r[3])
                        rs2 = rs1;                          // Forces a taken branch
                    skip = 1 + int'(imm[7:0]) % ((room < 3) ? room : 3);
                    boff = 13'(skip * 4);
                    imem[a] = {boff[12], boff[10:5], rs2, rs1, 3'b000, boff[4:1], boff[11],
                               7'b1100011};
                end
                default:
                    if (room >= 3)
                    begin
                        rd = rd | 5'd1;
                        joff = 21'd8;
                        imem[a] = {joff[20], joff[10:1], joff[11], joff[19:12], rd, 7'b1101111};
                        imem[a + 1] = {imm[11:0], rs1, 3'b000, rs2, 7'b0010011};
                        imem[a + 2] = {imm[23:17], rd, 5'd0, 3'b010, imm[16:12], 7'b0100011};
                        a = a + 2;
                    end
                    else
                        imem[a] = {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
            endcase
            a = a + 1;
        end
        // A store with an unsupported width stands in for an unknown word
        imem[end_idx] = end_illegal ? {7'd0, 5'd2, 5'd1, 3'b011, 5'd0, 7'b0100011}
                                    : 32'h0010_0073;
    endtask

    // ========================================
    // Sequencing
    // ========================================
    task automatic apply_reset();
        @(posedge clk);
        #5;
        reset = 1'b1;
        model_run = 1'b0;
        imem[0] = probe_store;                          // Store at the reset PC
        repeat (15)
        begin
            @(posedge clk);
            @(negedge clk);
            check_word("reset pc", base_addr, inst_addr);
            check_flag("reset halted", 1'b0, halted);
            check_flag("reset illegal", 1'b0, illegal);
            check_flag("reset store strobe", 1'b0, mem_w_en);
        end
    endtask

    task automatic start_program();
        @(posedge clk);
        #5;
        reset = 1'b0;
        model_pc = base_addr;
        model_regs = '{default: '0};
        model_halted = 1'b0;
        model_illegal = 1'b0;
        model_run = 1'b1;
    endtask

    task automatic finish_program();
        int cycles;
        word_t off;
        cycles = 0;
        while (halted !== 1'b1 && cycles < halt_timeout)
        begin
            @(negedge clk);
            cycles++;
        end
        if (halted !== 1'b1)
        begin
            $display("Timeout in %s: core did not halt within %0d cycles", test_name,
                     halt_timeout);
            other_errors++;
            return;
        end
        if (!model_halted)
        begin
            $display("Failure in %s: core halted before the end of the program", test_name);
            other_errors++;
        end
        check_flag("illegal flag", model_illegal, illegal);
        off = model_pc - base_addr;
        @(posedge clk);
        #5;
        imem[off[7:2]] = probe_store;                   // Halted core now fetches a store
        repeat (8)
        begin
            @(negedge clk);
            check_flag("halted flag", 1'b1, halted);
            check_word("pc after halt", model_pc, inst_addr);
            check_flag("store strobe after halt", 1'b0, mem_w_en);
        end
    endtask

    // Steps the model once per cycle, in the middle of the cycle
    always @(negedge clk)
    begin
        step_t s;
        if (model_run)
        begin
            s = iss_step(model_pc, model_regs, read_imem(model_pc));
            check_word("fetch address", model_pc, inst_addr);
            check_flag("store strobe", s.store_en, mem_w_en);
            if (s.store_en)
                check_store("store request", s.store, store);
            if (s.rd_en && s.rd != 5'd0)
                model_regs[s.rd] = s.rd_val;
            if (s.halt)
            begin
                model_run = 1'b0;
                model_halted = 1'b1;
                model_illegal = s.illegal;
            end
            else
                model_pc = s.next_pc;
        end
    end

    initial
    begin
        int t;
        reset = 1'b1;
        model_run = 1'b0;
        model_halted = 1'b0;
        model_illegal = 1'b0;
        model_pc = base_addr;
        seed = 32'hcafadec0;
        checks = 0;
        value_errors = 0;
        other_errors = 0;
        load_program(1'b0);
        for (t = 0; t < 4; t++)
        begin
            test_name = $sformatf("reset before program %0d", t);
            apply_reset();
            load_program(1'b0);
            test_name = $sformatf("program %0d", t);
            start_program();
            finish_program();
        end
        test_name = "illegal word";
        apply_reset();
        load_program(1'b1);
        start_program();
        finish_program();
        test_name = "reset mid-program";
        apply_reset();
        load_program(1'b0);
        start_program();
        repeat (6) @(posedge clk);
        test_name = "second reset";
        apply_reset();
        load_program(1'b0);
        test_name = "program after second reset";
        start_program();
        finish_program();
        $display("Checks: %0d, value errors: %0d, other errors: %0d", checks, value_errors,
                 other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* rv_pkg.sv */
package rv_pkg;

    // ========================================
    // Widths and addresses
    // ========================================
    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0] reg_idx_t;

    localparam word_t base_addr = 32'h8000_0000;    // Reset PC
    localparam word_t inst_bytes = 32'd4;           // Sequential PC step

    // ========================================
    // Instruction classes
    // ========================================
    typedef enum logic [2:0] {
        inst_none, inst_auipc, inst_jal, inst_beq,
        inst_sw, inst_addi, inst_add, inst_ebreak
    } inst_num_e;

    typedef enum logic [2:0] {
        type_none, type_r, type_i, type_s, type_b, type_u, type_j
    } inst_type_e;

    typedef enum logic [1:0] {
        alu_none, alu_add, alu_xor
    } alu_func_e;

    typedef struct packed {
        inst_num_e inst_num;
        inst_type_e inst_type;
        word_t imm;                                 // Already sign-extended
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
    } dec_t;

    typedef struct packed {
        word_t addr;
        word_t data;
    } store_t;

    // Lookup tables for the execute stage
    localparam int nr_inst_keys = 7;
    localparam int nr_type_keys = 6;

    localparam inst_num_e inst_keys [nr_inst_keys] = '{
        inst_auipc, inst_jal, inst_beq, inst_sw, inst_addi, inst_add, inst_ebreak
    };
    localparam inst_type_e type_keys [nr_type_keys] = '{
        type_r, type_i, type_s, type_b, type_u, type_j
    };

    // Encodings
    localparam logic [6:0] op_auipc = 7'b0010111;
    localparam logic [6:0] op_jal = 7'b1101111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_store = 7'b0100011;
    localparam logic [6:0] op_imm = 7'b0010011;
    localparam logic [6:0] op_reg = 7'b0110011;
    localparam logic [2:0] f3_zero = 3'b000;        // beq, addi, add
    localparam logic [2:0] f3_word = 3'b010;        // sw
    localparam word_t ebreak_word = 32'h0010_0073;

endpackage
